// File: flist.f
zcash_verif_pkg.sv
sol_ingest.sv
sol_index_unpack.sv
equihash_gen.sv
sol_check.sv
zcash_verif_equihash.sv
tb_zcash_verif_assert.sv
tb_zcash_verif_equihash.sv

// File: Bender.yml
package:
  name: zcash_verif_equihash

sources:
  - zcash_verif_pkg.sv
  - sol_ingest.sv
  - sol_index_unpack.sv
  - equihash_gen.sv
  - sol_check.sv
  - zcash_verif_equihash.sv
  - target: test
    files:
      - tb_zcash_verif_assert.sv
      - tb_zcash_verif_equihash.sv

// File: tb_zcash_verif_equihash.sv
// Equihash verifier testbench
`timescale 1ns/1ns
`default_nettype none

module tb_zcash_verif_equihash;

  localparam int DAT_BYTS = 4;
  // Cycles any single wait may take before the run is abandoned
  localparam int TIMEOUT  = 200;

  typedef logic [6:0] idx_list_t [8];

  logic        i_clk;
  logic        i_rst;
  logic [31:0] i_dat;
  logic        i_val;
  logic        i_sop;
  logic        i_eop;
  logic        o_rdy;
  logic [3:0]  o_mask;
  logic        o_mask_val;

  integer      seed;
  logic [3:0]  exp_q [$];

  zcash_verif_equihash #(
    .DAT_BYTS ( DAT_BYTS )
  ) i_zcash_verif_equihash (
    .i_clk      ( i_clk      ),
    .i_rst      ( i_rst      ),
    .i_dat      ( i_dat      ),
    .i_val      ( i_val      ),
    .i_sop      ( i_sop      ),
    .i_eop      ( i_eop      ),
    .o_rdy      ( o_rdy      ),
    .o_mask     ( o_mask     ),
    .o_mask_val ( o_mask_val )
  );

  always #10 i_clk = ~i_clk;

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Stand-in hash seeded from key and index and run through three add, rotate and xorshift rounds
  function automatic logic [23:0] ref_string(input logic [31:0] key, input logic [6:0] x);
    logic [31:0] v;
    logic [31:0] t;
    v = key ^ ({25'd0, x} * 32'h9E3779B1);
    for (int r = 0; r < 3; r++) begin
      t = v + {v[26:0], v[31:27]};
      v = t ^ (t >> 7);
    end
    return v[23:0];
  endfunction

  // Expected failure mask with bit 0 for xor, bit 1 for zero order, bit 2 for index order
  // and bit 3 for duplicates
  function automatic logic [3:0] equihash_ref(input logic [127:0] hdr, input idx_list_t idx);
    logic [31:0] key;
    logic [23:0] acc;
    logic [3:0]  mask;
    int          j;
    key  = '0;
    acc  = '0;
    mask = '0;
    for (int w = 0; w < 4; w++) key ^= hdr[127-32*w -: 32];
    for (int p = 0; p < 8; p++) begin
      acc ^= ref_string(key, idx[p]);
      j = p + 1;
      // A subtree of height h is complete once j strings are in
      for (int h = 1; h <= 3; h++) begin
        if (j % (1 << h) == 0) begin
          if ((acc >> (24 - 6 * h)) != 0) mask[1] = 1'b1;
          if (idx[j - (1 << (h - 1))] <= idx[j - (1 << h)]) mask[2] = 1'b1;
        end
      end
      for (int q = 0; q < p; q++) begin
        if (idx[q] == idx[p]) mask[3] = 1'b1;
      end
    end
    mask[0] = (acc != 0);
    return mask;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_val = 1'b0;
      i_sop = 1'b0;
      i_eop = 1'b0;
    end
  endtask

  // Drive the first n_beats beats of a block and optionally drop valid at random
  task automatic send_block(input logic [127:0] hdr, input idx_list_t idx,
                            input bit drop, input int n_beats);
    logic [63:0] sol;
    logic [31:0] beats [6];
    int          b;
    int          waited;
    sol = '0;
    for (int k = 0; k < 8; k++) sol[63-7*k -: 7] = idx[k];
    for (int w = 0; w < 4; w++) beats[w] = hdr[127-32*w -: 32];
    beats[4] = sol[63:32];
    beats[5] = sol[31:0];
    b      = 0;
    waited = 0;
    while (b < n_beats) begin
      @(negedge i_clk);
      i_dat = beats[b];
      i_sop = (b == 0);
      i_eop = (b == 5);
      i_val = !(drop && (($random(seed) & 3) == 0));
      // o_rdy only moves on a rising edge, so it is settled here
      if (i_val && o_rdy) begin
        b++;
        waited = 0;
      end else begin
        waited++;
        if (waited > TIMEOUT) stop_with_error("Input stream never accepted a beat");
      end
    end
  endtask

  task automatic send_and_expect(input logic [127:0] hdr, input idx_list_t idx,
                                 input bit drop, input int gap);
    send_block(hdr, idx, drop, 6);
    exp_q.push_back(equihash_ref(hdr, idx));
    idle_cycles(gap);
  endtask

  task automatic random_block(output logic [127:0] hdr, output idx_list_t idx);
    for (int w = 0; w < 4; w++) hdr[127-32*w -: 32] = $random(seed);
    for (int k = 0; k < 8; k++) idx[k] = $random(seed) & 7'h7f;
  endtask

  // Reset is held over two rising edges and o_rdy must rise on the next one
  task automatic apply_reset();
    i_rst = 1'b1;
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);
    compare_value("o_rdy", o_rdy, 1);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
      waited++;
      if (waited > TIMEOUT) stop_with_error("Expected masks never came out of the DUT");
    end
  endtask

  // Each mask pulse takes the oldest expected entry
  always @(negedge i_clk) begin
    if (o_mask_val === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_with_error("A mask came out with no block waiting for it");
      end else begin
        compare_value("o_mask", 32'(o_mask), 32'(exp_q.pop_front()));
      end
    end
  end

  initial begin
    logic [127:0] hdr;
    idx_list_t    idx;
    logic [6:0]   tmp;
    logic [3:0]   exp_mask;
    seed        = 49607;
    i_clk       = 1'b0;
    i_dat       = '0;
    apply_reset();

    // Random headers and indices with short idle gaps
    for (int n = 0; n < 20; n++) begin
      random_block(hdr, idx);
      send_and_expect(hdr, idx, 1'b0, $random(seed) & 3);
    end

    // Every index appears twice in a row so equal strings cancel
    for (int n = 0; n < 4; n++) begin
      random_block(hdr, idx);
      for (int k = 0; k < 8; k += 2) idx[k+1] = idx[k];
      exp_mask = equihash_ref(hdr, idx);
      compare_value("ref_xor_bit", exp_mask[0], 0);
      compare_value("ref_dup_bit", exp_mask[3], 1);
      send_and_expect(hdr, idx, 1'b0, 1);
    end

    // Distinct rising indices first and then the two top subtree heads swapped
    random_block(hdr, idx);
    idx = '{7'd3, 7'd10, 7'd17, 7'd25, 7'd40, 7'd55, 7'd90, 7'd120};
    exp_mask = equihash_ref(hdr, idx);
    compare_value("ref_order_bit", exp_mask[2], 0);
    compare_value("ref_dup_bit", exp_mask[3], 0);
    send_and_expect(hdr, idx, 1'b0, 2);
    tmp    = idx[0];
    idx[0] = idx[4];
    idx[4] = tmp;
    exp_mask = equihash_ref(hdr, idx);
    compare_value("ref_order_bit", exp_mask[2], 1);
    send_and_expect(hdr, idx, 1'b0, 2);
    wait_drain();

    // Back to back blocks with valid dropping fill ingest while unpack is busy
    for (int n = 0; n < 12; n++) begin
      random_block(hdr, idx);
      send_and_expect(hdr, idx, 1'b1, 0);
    end
    wait_drain();

    // One whole block is still being checked and the next is halfway in when reset hits
    // Neither may produce a mask, and a clean block after the reset must still match
    random_block(hdr, idx);
    send_block(hdr, idx, 1'b0, 6);
    random_block(hdr, idx);
    send_block(hdr, idx, 1'b0, 3);
    idle_cycles(3);
    apply_reset();
    random_block(hdr, idx);
    send_and_expect(hdr, idx, 1'b0, 0);
    wait_drain();
    idle_cycles(20);

    if (i_zcash_verif_equihash.i_tb_zcash_verif_assert.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_error("A protocol assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

// File: tb_zcash_verif_assert.sv
// Verifier protocol assertions
`timescale 1ns/1ns
`default_nettype none

module tb_zcash_verif_assert (
  input logic                                  i_clk,
  input logic                                  i_rst,
  input logic                                  i_rdy,
  input logic [zcash_verif_pkg::MASK_BITS-1:0] i_mask,
  input logic                                  i_mask_val
);

  // Count of failed assertions, read hierarchically at the end of the run
  int fail_cnt = 0;

  // One strobe per block, never stretched
  mask_pulse: assert property (@(posedge i_clk) disable iff (i_rst) i_mask_val |=> !i_mask_val)
    else begin
      fail_cnt++;
      $error("o_mask_val stayed high for two cycles");
    end

  // The mask must be fully driven whenever it is marked valid
  mask_known: assert property (@(posedge i_clk) disable iff (i_rst)
                               i_mask_val |-> !$isunknown(i_mask))
    else begin
      fail_cnt++;
      $error("o_mask has unknown bits while valid");
    end

  // Ingest comes out of reset not ready
  rdy_after_rst: assert property (@(posedge i_clk) i_rst |=> !i_rdy)
    else begin
      fail_cnt++;
      $error("o_rdy high right after a reset cycle");
    end

endmodule

bind zcash_verif_equihash tb_zcash_verif_assert i_tb_zcash_verif_assert (
  .i_clk      ( i_clk      ),
  .i_rst      ( i_rst      ),
  .i_rdy      ( o_rdy      ),
  .i_mask     ( o_mask     ),
  .i_mask_val ( o_mask_val )
);

`default_nettype wire

// File: zcash_verif_equihash.sv
// Equihash verifier top level
`timescale 1ns/1ns
`default_nettype none

module zcash_verif_equihash #(
  parameter int DAT_BYTS = 4
) (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic [DAT_BYTS*8-1:0]                 i_dat,
  input  logic                                  i_val,
  input  logic                                  i_sop,
  input  logic                                  i_eop,
  output logic                                  o_rdy,
  output logic [zcash_verif_pkg::MASK_BITS-1:0] o_mask,
  output logic                                  o_mask_val
);
  import zcash_verif_pkg::*;

  // Ingest to unpack
  logic [HDR_BYTS*8-1:0] ing_hdr;
  logic [SOL_BYTS*8-1:0] ing_sol;
  logic                  ing_val;
  logic                  unp_rdy;

  // Unpack to gen
  logic [SOL_BITS-1:0]   unp_idx;
  logic [KEY_BITS-1:0]   unp_key;
  logic [POS_BITS-1:0]   unp_pos;
  logic                  unp_val;

  // Gen to check
  logic [N-1:0]          gen_str;
  logic [SOL_BITS-1:0]   gen_idx;
  logic [POS_BITS-1:0]   gen_pos;
  logic                  gen_val;

  sol_ingest #(
    .DAT_BYTS ( DAT_BYTS )
  ) i_sol_ingest (
    .i_clk     ( i_clk   ),
    .i_rst     ( i_rst   ),
    .i_dat     ( i_dat   ),
    .i_val     ( i_val   ),
    .i_sop     ( i_sop   ),
    .i_eop     ( i_eop   ),
    .i_unp_rdy ( unp_rdy ),
    .o_rdy     ( o_rdy   ),
    .o_hdr     ( ing_hdr ),
    .o_sol     ( ing_sol ),
    .o_val     ( ing_val )
  );

  sol_index_unpack i_sol_index_unpack (
    .i_clk ( i_clk   ),
    .i_rst ( i_rst   ),
    .i_hdr ( ing_hdr ),
    .i_sol ( ing_sol ),
    .i_val ( ing_val ),
    .o_rdy ( unp_rdy ),
    .o_idx ( unp_idx ),
    .o_key ( unp_key ),
    .o_pos ( unp_pos ),
    .o_val ( unp_val )
  );

  equihash_gen i_equihash_gen (
    .i_clk ( i_clk   ),
    .i_rst ( i_rst   ),
    .i_idx ( unp_idx ),
    .i_key ( unp_key ),
    .i_pos ( unp_pos ),
    .i_val ( unp_val ),
    .o_str ( gen_str ),
    .o_idx ( gen_idx ),
    .o_pos ( gen_pos ),
    .o_val ( gen_val )
  );

  sol_check i_sol_check (
    .i_clk      ( i_clk      ),
    .i_rst      ( i_rst      ),
    .i_str      ( gen_str    ),
    .i_idx      ( gen_idx    ),
    .i_pos      ( gen_pos    ),
    .i_val      ( gen_val    ),
    .o_mask     ( o_mask     ),
    .o_mask_val ( o_mask_val )
  );

endmodule

`default_nettype wire

// File: sol_check.sv
// Equihash solution checker
`timescale 1ns/1ns
`default_nettype none

module sol_check (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic [zcash_verif_pkg::N-1:0]         i_str,
  input  logic [zcash_verif_pkg::SOL_BITS-1:0]  i_idx,
  input  logic [zcash_verif_pkg::POS_BITS-1:0]  i_pos,
  input  logic                                  i_val,
  output logic [zcash_verif_pkg::MASK_BITS-1:0] o_mask,
  output logic                                  o_mask_val
);
  import zcash_verif_pkg::*;

  logic [N-1:0]         run_xor;
  logic [N-1:0]         xor_nxt;
  logic [SOL_BITS-1:0]  idx_tbl [SOL_LIST_LEN];
  logic [SOL_BITS-1:0]  idx_now [SOL_LIST_LEN];
  logic [POS_BITS:0]    cnt_j;
  logic [POS_BITS-1:0]  lpos;
  logic [POS_BITS-1:0]  rpos;
  logic                 zero_bad;
  logic                 order_bad;
  logic                 dup_fnd;
  logic                 zero_hit;
  logic                 order_hit;
  logic                 dup_hit;
  logic                 last;
  logic [MASK_BITS-1:0] mask_nxt;

  always_comb begin
    // Running XOR with the arriving string already folded in
    xor_nxt = run_xor ^ i_str;
    // Count of strings seen so far, including this one
    cnt_j = {1'b0, i_pos} + 1'b1;

    // Table view where the current index already sits at its position
    idx_now         = idx_tbl;
    idx_now[i_pos]  = i_idx;

    zero_hit  = 1'b0;
    order_hit = 1'b0;
    dup_hit   = 1'b0;
    lpos      = '0;
    rpos      = '0;

    // A subtree of height i+1 closes whenever j is a multiple of 2^(i+1)
    for (int i = 0; i < K; i++) begin
      if ((int'(cnt_j) & ((2 << i) - 1)) == 0) begin
        // Its XOR must have (i+1) collision fields of zeros at the top
        if (|(xor_nxt & ~({N{1'b1}} >> ((i + 1) * COLLISION_BIT_LEN)))) begin
          zero_hit = 1'b1;
        end
        // Heads of its two halves must be in strictly rising order
        rpos = POS_BITS'(int'(cnt_j) - (1 << i));
        lpos = POS_BITS'(int'(cnt_j) - (2 << i));
        if (idx_now[rpos] <= idx_now[lpos]) begin
          order_hit = 1'b1;
        end
      end
    end

    // Only entries written earlier in this block are compared
    for (int q = 0; q < SOL_LIST_LEN; q++) begin
      if (q < int'(i_pos) && idx_tbl[q] == i_idx) dup_hit = 1'b1;
    end

    last = i_val && (i_pos == POS_BITS'(SOL_LIST_LEN - 1));

    mask_nxt                       = '0;
    mask_nxt[MASK_XOR_NON_ZERO]    = |xor_nxt;
    mask_nxt[MASK_BAD_ZERO_ORDER]  = zero_bad | zero_hit;
    mask_nxt[MASK_BAD_INDEX_ORDER] = order_bad | order_hit;
    mask_nxt[MASK_DUPLICATE_FND]   = dup_fnd | dup_hit;
  end

  // Index table and result register
  always_ff @(posedge i_clk) begin
    if (i_val) idx_tbl[i_pos] <= i_idx;
    if (last) o_mask <= mask_nxt;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      run_xor    <= '0;
      zero_bad   <= 1'b0;
      order_bad  <= 1'b0;
      dup_fnd    <= 1'b0;
      o_mask_val <= 1'b0;
    end else begin
      // Single cycle pulse per block
      o_mask_val <= last;
      if (last) begin
        // Ready for the next block straight away
        run_xor   <= '0;
        zero_bad  <= 1'b0;
        order_bad <= 1'b0;
        dup_fnd   <= 1'b0;
      end else if (i_val) begin
        run_xor   <= xor_nxt;
        zero_bad  <= zero_bad | zero_hit;
        order_bad <= order_bad | order_hit;
        dup_fnd   <= dup_fnd | dup_hit;
      end
    end
  end

endmodule

`default_nettype wire

// File: equihash_gen.sv
// Equihash string generator
`timescale 1ns/1ns
`default_nettype none

module equihash_gen (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  input  logic [zcash_verif_pkg::SOL_BITS-1:0] i_idx,
  input  logic [zcash_verif_pkg::KEY_BITS-1:0] i_key,
  input  logic [zcash_verif_pkg::POS_BITS-1:0] i_pos,
  input  logic                                 i_val,
  output logic [zcash_verif_pkg::N-1:0]        o_str,
  output logic [zcash_verif_pkg::SOL_BITS-1:0] o_idx,
  output logic [zcash_verif_pkg::POS_BITS-1:0] o_pos,
  output logic                                 o_val
);
  import zcash_verif_pkg::*;

  // Rounds done in the first stage
  localparam int S1_ROUNDS = 1;

  logic [31:0]         s1_mix;
  logic [SOL_BITS-1:0] s1_idx;
  logic [POS_BITS-1:0] s1_pos;
  logic                s1_val;

  // Stage 1 seeds the value from key and index and runs the first round
  // Index and position travel next to the value so check can match them up
  always_ff @(posedge i_clk) begin
    s1_mix <= mix_round(mix_seed(i_key, i_idx));
    s1_idx <= i_idx;
    s1_pos <= i_pos;
  end

  // Stage 2 runs the remaining rounds and truncates to the string width
  always_ff @(posedge i_clk) begin
    o_str <= equihash_mix(s1_mix, S1_ROUNDS);
    o_idx <= s1_idx;
    o_pos <= s1_pos;
  end

  // Valid bits shadow the data, so two items can be in flight at once
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      o_val  <= 1'b0;
    end else begin
      s1_val <= i_val;
      o_val  <= s1_val;
    end
  end

endmodule

`default_nettype wire

// File: sol_index_unpack.sv
// Solution index unpacker
`timescale 1ns/1ns
`default_nettype none

module sol_index_unpack (
  input  logic                                   i_clk,
  input  logic                                   i_rst,
  input  logic [zcash_verif_pkg::HDR_BYTS*8-1:0] i_hdr,
  input  logic [zcash_verif_pkg::SOL_BYTS*8-1:0] i_sol,
  input  logic                                   i_val,
  output logic                                   o_rdy,
  output logic [zcash_verif_pkg::SOL_BITS-1:0]   o_idx,
  output logic [zcash_verif_pkg::KEY_BITS-1:0]   o_key,
  output logic [zcash_verif_pkg::POS_BITS-1:0]   o_pos,
  output logic                                   o_val
);
  import zcash_verif_pkg::*;

  localparam int SOL_W = SOL_BYTS * 8;

  unpack_state_t       state;
  logic [KEY_BITS-1:0] key_q;
  logic [SOL_W-1:0]    sol_sr;
  logic [POS_BITS-1:0] cnt;
  logic                take;

  // A new block is taken only between runs
  assign o_rdy = (state == UNP_IDLE);
  assign take  = i_val && o_rdy;

  // The key stays put for the whole run, so it goes out straight from its latch
  assign o_key = key_q;

  // Indices leave from the top of the shift register, big-endian bit order
  // The padding bits at the bottom are shifted in but never read
  always_ff @(posedge i_clk) begin
    if (take) begin
      key_q  <= mix_key(i_hdr);
      sol_sr <= i_sol;
    end else if (state == UNP_RUN) begin
      sol_sr <= sol_sr << SOL_BITS;
    end
    o_idx <= sol_sr[SOL_W-1 -: SOL_BITS];
    o_pos <= cnt;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= UNP_IDLE;
      cnt   <= '0;
      o_val <= 1'b0;
    end else begin
      // One index per cycle for exactly SOL_LIST_LEN cycles
      o_val <= (state == UNP_RUN);
      case (state)
        UNP_IDLE: begin
          cnt <= '0;
          if (take) state <= UNP_RUN;
        end
        UNP_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == POS_BITS'(SOL_LIST_LEN - 1)) begin
            state <= UNP_IDLE;
          end
        end
        default: state <= UNP_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sol_ingest.sv
// Solution stream ingest
`timescale 1ns/1ns
`default_nettype none

module sol_ingest #(
  parameter int DAT_BYTS = 4
) (
  input  logic                                   i_clk,
  input  logic                                   i_rst,
  input  logic [DAT_BYTS*8-1:0]                  i_dat,
  input  logic                                   i_val,
  input  logic                                   i_sop,
  input  logic                                   i_eop,
  input  logic                                   i_unp_rdy,
  output logic                                   o_rdy,
  output logic [zcash_verif_pkg::HDR_BYTS*8-1:0] o_hdr,
  output logic [zcash_verif_pkg::SOL_BYTS*8-1:0] o_sol,
  output logic                                   o_val
);
  import zcash_verif_pkg::*;

  localparam int DAT_BITS = DAT_BYTS * 8;
  localparam int BLK_BYTS = HDR_BYTS + SOL_BYTS;
  localparam int CNT_BITS = $clog2(BLK_BYTS + 1);

  ingest_state_t       state;
  logic [CNT_BITS-1:0] byt_cnt;
  logic [CNT_BITS-1:0] wr_ofs;
  logic [CNT_BITS-1:0] nxt_cnt;
  logic                beat;
  logic                wr_en;

  assign beat = i_val && o_rdy;

  // A start of packet always lands at byte 0, whatever came before it
  assign wr_ofs  = i_sop ? '0 : byt_cnt;
  assign nxt_cnt = wr_ofs + CNT_BITS'(DAT_BYTS);

  // Beats outside a packet are dropped while idle
  assign wr_en = beat && (i_sop || state == ING_HDR || state == ING_SOL);

  // The block is offered to unpack for as long as it sits here
  assign o_val = (state == ING_FULL);

  // Byte 0 of the block is the top byte of the header register
  // Solution bytes follow the same order inside the solution buffer
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      if (wr_ofs < CNT_BITS'(HDR_BYTS)) begin
        o_hdr[(HDR_BYTS - DAT_BYTS - int'(wr_ofs))*8 +: DAT_BITS] <= i_dat;
      end else if (wr_ofs <= CNT_BITS'(BLK_BYTS - DAT_BYTS)) begin
        o_sol[(BLK_BYTS - DAT_BYTS - int'(wr_ofs))*8 +: DAT_BITS] <= i_dat;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= ING_IDLE;
      byt_cnt <= '0;
      o_rdy   <= 1'b0;
    end else begin
      case (state)
        ING_IDLE, ING_HDR, ING_SOL: begin
          o_rdy <= 1'b1;
          if (wr_en) begin
            byt_cnt <= nxt_cnt;
            if (i_eop) begin
              // Last beat, so hold the block and stop the input
              state <= ING_FULL;
              o_rdy <= 1'b0;
            end else if (nxt_cnt >= CNT_BITS'(HDR_BYTS)) begin
              state <= ING_SOL;
            end else begin
              state <= ING_HDR;
            end
          end
        end
        ING_FULL: begin
          // Unpack latches the block on this edge, the input reopens
          if (i_unp_rdy) begin
            state   <= ING_IDLE;
            byt_cnt <= '0;
            o_rdy   <= 1'b1;
          end
        end
        default: state <= ING_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: zcash_verif_pkg.sv
// Equihash verifier definitions
`default_nettype none

package zcash_verif_pkg;

  // Scaled Equihash sizes, n=24 and k=3
  localparam int N                 = 24;
  localparam int K                 = 3;
  localparam int COLLISION_BIT_LEN = N / (K + 1);
  localparam int SOL_BITS          = COLLISION_BIT_LEN + 1;
  localparam int SOL_LIST_LEN      = 2 ** K;
  localparam int POS_BITS          = $clog2(SOL_LIST_LEN);
  // Eight 7-bit indices take 56 bits, padded up to a whole 8 bytes
  localparam int SOL_BYTS          = 8;
  localparam int HDR_BYTS          = 16;
  localparam int KEY_BITS          = 32;

  // Failure mask layout
  localparam int MASK_BITS            = 4;
  localparam int MASK_XOR_NON_ZERO    = 0;
  localparam int MASK_BAD_ZERO_ORDER  = 1;
  localparam int MASK_BAD_INDEX_ORDER = 2;
  localparam int MASK_DUPLICATE_FND   = 3;

  // Mixing constants that stand in for Blake2b
  localparam int          MIX_ROUNDS = 3;
  localparam logic [31:0] MIX_GOLDEN = 32'h9E37_79B1;

  typedef enum logic [1:0] {ING_IDLE, ING_HDR, ING_SOL, ING_FULL} ingest_state_t;
  typedef enum logic {UNP_IDLE, UNP_RUN} unpack_state_t;

  // Fold the header words into one key, word 0 holds stream bytes 0 to 3
  function automatic logic [KEY_BITS-1:0] mix_key(input logic [HDR_BYTS*8-1:0] hdr);
    logic [KEY_BITS-1:0] key;
    key = '0;
    for (int w = 0; w < HDR_BYTS / 4; w++) begin
      key = key ^ hdr[HDR_BYTS*8-1-w*32 -: 32];
    end
    return key;
  endfunction

  // Seed value for index x, the product wraps modulo 2^32
  function automatic logic [31:0] mix_seed(input logic [KEY_BITS-1:0] key,
                                           input logic [SOL_BITS-1:0] idx);
    logic [31:0] prod;
    prod = 32'(idx) * MIX_GOLDEN;
    return key ^ prod;
  endfunction

  // One round adds the left rotation by 5, then folds in the right shift by 7
  function automatic logic [31:0] mix_round(input logic [31:0] v);
    logic [31:0] t;
    t = v + {v[26:0], v[31:27]};
    return t ^ (t >> 7);
  endfunction

  // Finish the rounds not yet done on a seed and keep the low N bits
  // Called with done set to 0 on a fresh seed this gives the whole string
  function automatic logic [N-1:0] equihash_mix(input logic [31:0] v, input int done);
    logic [31:0] t;
    t = v;
    for (int r = 0; r < MIX_ROUNDS; r++) begin
      if (r >= done) t = mix_round(t);
    end
    return t[N-1:0];
  endfunction

endpackage

`default_nettype wire
